// File: Makefile
SIM := obj_dir/Vtb_exec_backend
SRCS := verilog.f $(wildcard verilog/*.sv verilog/*.svh verif/*.sv)

.PHONY: all run clean

all: $(SIM)

$(SIM): $(SRCS)
	verilator --binary --timing -j 0 -f verilog.f --top-module tb_exec_backend -o Vtb_exec_backend

run: $(SIM)
	./$(SIM)

clean:
	rm -rf obj_dir

// File: verif/tb_exec_backend.sv
`timescale 1ns/1ns

module tb_exec_backend;

  import rv_types_pkg::*;
  import pipe_stage_pkg::*;

  logic    clk = 1'b0;
  logic    rst_i;
  logic    issue_valid;
  issue_t  issue;
  logic    issue_ready;
  logic    flush;
  logic    cyc;
  logic    stb;
  wb_req_t wb_req;
  wb_rsp_t wb_rsp;
  logic    retire_valid;
  retire_t retire;

  xlen_t   mem_sh [0:255];  // memory shadow
  xlen_t   regs [0:31];     // register shadow
  retire_t exp_q [$];
  retire_t exp_r;
  int      mem_ops = 0;
  int      acks = 0;
  wb_req_t prev_req;
  logic    prev_cyc = 1'b0;
  logic    prev_ack = 1'b0;

  always #10 clk = ~clk;

  exec_backend u_exec_backend (
    .clk            (clk),
    .rst_i          (rst_i),
    .issue_valid_i  (issue_valid),
    .issue_i        (issue),
    .issue_ready_o  (issue_ready),
    .flush_i        (flush),
    .wb_cyc_o       (cyc),
    .wb_stb_o       (stb),
    .wb_req_o       (wb_req),
    .wb_i           (wb_rsp),
    .retire_valid_o (retire_valid),
    .retire_o       (retire)
  );

  wb_mem_model u_mem (
    .clk   (clk),
    .rst_i (rst_i),
    .cyc_i (cyc),
    .stb_i (stb),
    .req_i (wb_req),
    .rsp_o (wb_rsp)
  );

  task check_eq(input string what, input xlen_t act, input xlen_t exp);
    if (act !== exp) begin
      $display("Fail at %0t: %s got %h expected %h", $time, what, act, exp);
      $display("TEST FAILED");
      $fatal(1, "value mismatch");
    end
  endtask

  task fail_plain(input string msg);
    $display("%s", msg);
    $display("TEST FAILED");
    $fatal(1, "%s", msg);
  endtask

  function automatic xlen_t alu_ref(alu_op_t op, xlen_t a, xlen_t b);
    case (op)
      ALU_ADD:   return a + b;
      ALU_SUB:   return a - b;
      ALU_SLL:   return a << b[4:0];
      ALU_SLT:   return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
      ALU_SLTU:  return (a < b) ? 32'd1 : 32'd0;
      ALU_XOR:   return a ^ b;
      ALU_SRL:   return a >> b[4:0];
      ALU_SRA:   return xlen_t'($signed(a) >>> b[4:0]);
      ALU_OR:    return a | b;
      ALU_AND:   return a & b;
      ALU_PASSB: return b;
      default:   return '0;
    endcase
  endfunction

  function automatic xlen_t load_ref(mem_op_t op, xlen_t word, logic [1:0] lane);
    xlen_t sh;
    sh = word >> (8 * lane);
    case (op)
      MEMOP_LB:  return {{24{sh[7]}}, sh[7:0]};
      MEMOP_LBU: return {24'd0, sh[7:0]};
      MEMOP_LH:  return {{16{sh[15]}}, sh[15:0]};
      MEMOP_LHU: return {16'd0, sh[15:0]};
      default:   return word;
    endcase
  endfunction

  task store_ref(input mem_op_t op, input xlen_t addr, input xlen_t data);
    xlen_t shifted;
    logic  hit;
    shifted = data << (8 * addr[1:0]);
    for (int b = 0; b < 4; b++) begin
      hit = (op == MEMOP_SW) || (op == MEMOP_SB && b == addr[1:0]) ||
            (op == MEMOP_SH && (b / 2) == addr[1]);
      if (hit) begin
        mem_sh[addr[9:2]][8*b +: 8] = shifted[8*b +: 8];
      end
    end
  endtask

  function automatic issue_t rand_alu();
    issue_t o;
    o.alu_op   = alu_op_t'($urandom % 11);
    o.mem_op   = MEMOP_NONE;
    o.rd_idx   = reg_idx_t'($urandom % 32);
    o.rd_wen   = ($urandom % 4) != 0;
    o.use_imm  = 1'($urandom % 2);
    o.rs1_data = ($urandom % 2) ? regs[$urandom % 32] : $urandom;
    o.rs2_data = $urandom;
    o.imm_data = $urandom;
    return o;
  endfunction

  function automatic issue_t mem_issue(mem_op_t mop, int word, logic [1:0] lane,
                                       xlen_t data, reg_idx_t rd);
    issue_t o;
    o.alu_op   = ALU_ADD;
    o.mem_op   = mop;
    o.rd_idx   = rd;
    o.rd_wen   = (mop < MEMOP_SB) || 1'($urandom % 2);  // stores may carry a stray rd_wen
    o.use_imm  = 1'b1;
    o.imm_data = xlen_t'($urandom % 64);
    o.rs1_data = xlen_t'(word * 4 + lane) - o.imm_data;  // base plus offset
    o.rs2_data = data;
    return o;
  endfunction

  // any access kind, lane aligned to its size
  function automatic issue_t rand_mem(int words);
    mem_op_t    mop;
    logic [1:0] lane;
    mop  = mem_op_t'($urandom % 8 + 1);
    lane = 2'($urandom % 4);
    if (mop == MEMOP_LH || mop == MEMOP_LHU || mop == MEMOP_SH) begin
      lane[0] = 1'b0;
    end else if (mop == MEMOP_LW || mop == MEMOP_SW) begin
      lane = 2'd0;
    end
    return mem_issue(mop, $urandom % words, lane, $urandom, reg_idx_t'($urandom % 32));
  endfunction

  task send(input issue_t op, input logic fl);
    int      waited;
    xlen_t   res;
    retire_t r;
    logic    is_st;
    issue       = op;
    issue_valid = 1'b1;
    flush       = fl;
    waited      = 0;
    while (!issue_ready) begin
      @(negedge clk);
      waited++;
      if (waited > 50) begin
        fail_plain("issue port stuck, ready never came back");
      end
    end
    @(posedge clk);  // accepted here
    if (!fl) begin
      res   = alu_ref(op.alu_op, op.rs1_data, op.use_imm ? op.imm_data : op.rs2_data);
      is_st = op.mem_op >= MEMOP_SB;
      r.rd_idx  = op.rd_idx;
      r.rd_data = res;
      if (op.mem_op != MEMOP_NONE) begin
        mem_ops++;
        if (is_st) begin
          store_ref(op.mem_op, res, op.rs2_data);
        end else begin
          r.rd_data = load_ref(op.mem_op, mem_sh[res[9:2]], res[1:0]);
        end
      end
      if (!is_st && op.rd_wen && op.rd_idx != 0) begin
        exp_q.push_back(r);
        regs[op.rd_idx] = r.rd_data;
      end
    end
    @(negedge clk);
    issue_valid = 1'b0;
    flush       = 1'b0;
  endtask

  // retire order and bus protocol
  always @(negedge clk) begin
    if (!rst_i) begin
      check_eq("wb_stb_o vs wb_cyc_o", 32'(stb), 32'(cyc));
      if (prev_cyc && !prev_ack) begin
        check_eq("wb_cyc_o held until ack", 32'(cyc), 32'd1);
        check_eq("adr held", wb_req.adr, prev_req.adr);
        check_eq("dat held", wb_req.dat, prev_req.dat);
        check_eq("sel held", 32'(wb_req.sel), 32'(prev_req.sel));
        check_eq("we held", 32'(wb_req.we), 32'(prev_req.we));
      end
      if (cyc && wb_rsp.ack) begin
        acks++;
      end
      if (retire_valid) begin
        if (exp_q.size() == 0) begin
          fail_plain("a retire came out with no operation outstanding");
        end
        exp_r = exp_q.pop_front();
        check_eq("retire rd_idx", 32'(retire.rd_idx), 32'(exp_r.rd_idx));
        check_eq("retire rd_data", retire.rd_data, exp_r.rd_data);
      end
    end
    prev_cyc = cyc;
    prev_ack = wb_rsp.ack;
    prev_req = wb_req;
  end

  initial begin
    int         w;
    int         waited;
    logic [1:0] lane;
    xlen_t      d;
    void'($urandom(82966));
    for (int i = 0; i < 256; i++) begin
      mem_sh[i] = {8'(i), ~8'(i), 8'(i) ^ 8'h5a, 8'(i + 1)};
    end
    for (int i = 0; i < 32; i++) begin
      regs[i] = '0;
    end
    rst_i       = 1'b1;
    issue_valid = 1'b0;
    issue       = '0;
    flush       = 1'b0;
    repeat (16) @(negedge clk);
    rst_i = 1'b0;

    check_eq("retire_valid_o after reset", 32'(retire_valid), 32'd0);
    check_eq("wb_cyc_o after reset", 32'(cyc), 32'd0);
    check_eq("wb_stb_o after reset", 32'(stb), 32'd0);
    check_eq("issue_ready_o after reset", 32'(issue_ready), 32'd1);

    repeat (200) send(rand_alu(), 1'b0);

    repeat (30) begin
      w = $urandom % 256;
      send(mem_issue(MEMOP_SW, w, 2'd0, $urandom, '0), 1'b0);
      send(mem_issue(MEMOP_LW, w, 2'd0, '0, reg_idx_t'($urandom % 31 + 1)), 1'b0);
    end

    // partial stores then word and narrow loads on the same word
    repeat (60) begin
      w    = $urandom % 256;
      lane = 2'($urandom % 4);
      d    = $urandom;
      if ($urandom % 2) begin
        send(mem_issue(MEMOP_SB, w, lane, d, '0), 1'b0);
      end else begin
        send(mem_issue(MEMOP_SH, w, {lane[1], 1'b0}, d, '0), 1'b0);
      end
      send(mem_issue(MEMOP_LW, w, 2'd0, '0, 5'd7), 1'b0);
      send(mem_issue(mem_op_t'($urandom % 4 + 1), w, {lane[1], 1'b0}, '0, 5'd9), 1'b0);
    end

    repeat (300) begin
      if ($urandom % 2) begin
        send(rand_mem(16), 1'b0);
      end else begin
        send(rand_alu(), 1'b0);
      end
    end

    repeat (40) begin
      send(rand_alu(), 1'b0);
      send(($urandom % 2) ? rand_mem(16) : rand_alu(), 1'b1);
      send(rand_mem(16), 1'b0);
    end

    waited = 0;
    while (exp_q.size() != 0 || cyc) begin
      @(negedge clk);
      waited++;
      if (waited > 100) begin
        fail_plain("pipeline did not drain, operations still outstanding");
      end
    end
    repeat (4) @(negedge clk);
    check_eq("bus cycles vs memory operations", 32'(acks), 32'(mem_ops));
    $display("TEST OK");
    $finish;
  end

endmodule

// File: verif/wb_mem_model.sv
`timescale 1ns/1ns

module wb_mem_model (
  input  logic                    clk,
  input  logic                    rst_i,
  input  logic                    cyc_i,
  input  logic                    stb_i,
  input  pipe_stage_pkg::wb_req_t req_i,
  output pipe_stage_pkg::wb_rsp_t rsp_o
);

  logic [31:0] mem [0:255];
  logic [1:0]  wait_cnt;
  logic [7:0]  idx;
  int          i;

  assign idx = req_i.adr[9:2];  // 256 words

  initial begin
    for (i = 0; i < 256; i++) begin
      mem[i] = {8'(i), ~8'(i), 8'(i) ^ 8'h5a, 8'(i + 1)};
    end
  end

  // ack is registered, 0 to 3 extra wait states per cycle
  always @(posedge clk) begin
    if (rst_i) begin
      rsp_o.ack <= 1'b0;
      rsp_o.dat <= '0;
      wait_cnt  <= '0;
    end else if (rsp_o.ack) begin
      rsp_o.ack <= 1'b0;
      wait_cnt  <= 2'($urandom % 4);  // fresh delay for the next cycle
    end else if (cyc_i && stb_i) begin
      if (wait_cnt == 0) begin
        rsp_o.ack <= 1'b1;
        rsp_o.dat <= mem[idx];
        if (req_i.we) begin
          for (int b = 0; b < 4; b++) begin
            if (req_i.sel[b]) begin
              mem[idx][8*b +: 8] <= req_i.dat[8*b +: 8];
            end
          end
        end
      end else begin
        wait_cnt <= wait_cnt - 2'd1;
      end
    end
  end

endmodule

// File: verilog.f
+incdir+verilog
verilog/rv_types_pkg.sv
verilog/pipe_stage_pkg.sv
verilog/alu_unit.sv
verilog/ex_mem.sv
verilog/lsu_wb.sv
verilog/exec_backend.sv
verif/wb_mem_model.sv
verif/tb_exec_backend.sv

// File: verilog/alu_unit.sv
`timescale 1ns/1ns
`include "core_settings.svh"

module alu_unit (
  input  rv_types_pkg::alu_op_t op_i,
  input  rv_types_pkg::xlen_t   a_i,
  input  rv_types_pkg::xlen_t   b_i,
  output rv_types_pkg::xlen_t   result_o
);

  import rv_types_pkg::*;

  localparam int SHAMT_W = $clog2(`XLEN);

  logic [SHAMT_W-1:0] shamt;
  logic               lt_signed;
  logic               lt_unsigned;
  xlen_t              sra_res;

  assign shamt       = b_i[SHAMT_W-1:0];  // only the low bits count
  assign lt_signed   = $signed(a_i) < $signed(b_i);
  assign lt_unsigned = a_i < b_i;

  // arithmetic shift keeps the sign bit
  assign sra_res = $signed(a_i) >>> shamt;

  always_comb begin
    case (op_i)
      ALU_ADD: begin
        result_o = a_i + b_i;
      end
      ALU_SUB: begin
        result_o = a_i - b_i;
      end
      ALU_SLL: begin
        result_o = a_i << shamt;
      end
      ALU_SLT: begin
        result_o = xlen_t'(lt_signed);
      end
      ALU_SLTU: begin
        result_o = xlen_t'(lt_unsigned);
      end
      ALU_XOR: begin
        result_o = a_i ^ b_i;
      end
      ALU_SRL: begin
        result_o = a_i >> shamt;
      end
      ALU_SRA: begin
        result_o = sra_res;
      end
      ALU_OR: begin
        result_o = a_i | b_i;
      end
      ALU_AND: begin
        result_o = a_i & b_i;
      end
      ALU_PASSB: begin
        result_o = b_i;  // lui
      end
      default: begin
        result_o = '0;
      end
    endcase
  end

endmodule

// File: verilog/core_settings.svh
`ifndef CORE_SETTINGS_SVH
`define CORE_SETTINGS_SVH

// data path width
`define XLEN 32

// register file index
`define REG_ADDRWIDTH 5

// byte lanes on the data bus
`define WB_SEL_LEN 4

`endif

// File: verilog/ex_mem.sv
`timescale 1ns/1ns

module ex_mem (
  input  logic                    clk,
  input  logic                    rst_i,
  input  logic                    stall_i,
  input  logic                    flush_i,
  input  pipe_stage_pkg::ex_mem_t slot_i,
  output pipe_stage_pkg::ex_mem_t slot_o
);

  import rv_types_pkg::*;

  logic load_bubble;
  logic load_slot;

  // stall wins over flush
  assign load_bubble = rst_i || (flush_i && !stall_i);
  assign load_slot   = !stall_i;

  always_ff @(posedge clk) begin
    if (load_bubble) begin
      slot_o.valid  <= 1'b0;
      slot_o.mem_op <= MEMOP_NONE;
      slot_o.rd_wen <= 1'b0;
    end else if (load_slot) begin
      slot_o <= slot_i;
    end
  end

endmodule

// File: verilog/exec_backend.sv
`timescale 1ns/1ns

module exec_backend (
  input  logic                    clk,
  input  logic                    rst_i,
  input  logic                    issue_valid_i,
  input  pipe_stage_pkg::issue_t  issue_i,
  output logic                    issue_ready_o,
  input  logic                    flush_i,
  output logic                    wb_cyc_o,
  output logic                    wb_stb_o,
  output pipe_stage_pkg::wb_req_t wb_req_o,
  input  pipe_stage_pkg::wb_rsp_t wb_i,
  output logic                    retire_valid_o,
  output pipe_stage_pkg::retire_t retire_o
);

  import rv_types_pkg::*;
  import pipe_stage_pkg::*;

  xlen_t   alu_b;
  xlen_t   alu_result;
  ex_mem_t slot_d;
  ex_mem_t slot_q;
  logic    lsu_stall;

  assign alu_b = issue_i.use_imm ? issue_i.imm_data : issue_i.rs2_data;

  alu_unit u_alu_unit (
    .op_i     (issue_i.alu_op),
    .a_i      (issue_i.rs1_data),
    .b_i      (alu_b),
    .result_o (alu_result)
  );

  // slot is only valid on a completed handshake
  always_comb begin
    slot_d.valid    = issue_valid_i && issue_ready_o;
    slot_d.mem_op   = issue_i.mem_op;
    slot_d.rd_idx   = issue_i.rd_idx;
    slot_d.rd_wen   = issue_i.rd_wen;
    slot_d.alu_data = alu_result;       // address for loads and stores
    slot_d.rs2_data = issue_i.rs2_data;
  end

  assign issue_ready_o = !lsu_stall;

  ex_mem u_ex_mem (
    .clk     (clk),
    .rst_i   (rst_i),
    .stall_i (lsu_stall),
    .flush_i (flush_i),
    .slot_i  (slot_d),
    .slot_o  (slot_q)
  );

  lsu_wb u_lsu_wb (
    .clk            (clk),
    .rst_i          (rst_i),
    .slot_i         (slot_q),
    .stall_o        (lsu_stall),
    .wb_cyc_o       (wb_cyc_o),
    .wb_stb_o       (wb_stb_o),
    .wb_req_o       (wb_req_o),
    .wb_i           (wb_i),
    .retire_valid_o (retire_valid_o),
    .retire_o       (retire_o)
  );

endmodule

// File: verilog/lsu_wb.sv
`timescale 1ns/1ns
`include "core_settings.svh"

module lsu_wb (
  input  logic                    clk,
  input  logic                    rst_i,
  input  pipe_stage_pkg::ex_mem_t slot_i,
  output logic                    stall_o,
  output logic                    wb_cyc_o,
  output logic                    wb_stb_o,
  output pipe_stage_pkg::wb_req_t wb_req_o,
  input  pipe_stage_pkg::wb_rsp_t wb_i,
  output logic                    retire_valid_o,
  output pipe_stage_pkg::retire_t retire_o
);

  import rv_types_pkg::*;

  typedef enum logic {
    IDLE,
    BUS
  } lsu_state_e;

  lsu_state_e state_q;
  lsu_state_e state_d;
  logic       is_load;
  logic       is_store;
  logic       mem_req;
  logic       bus_done;
  logic       rd_write;
  logic [1:0] lane;
  xlen_t      lane_data;
  xlen_t      load_data;

  assign is_load = (slot_i.mem_op == MEMOP_LB) || (slot_i.mem_op == MEMOP_LBU) ||
                   (slot_i.mem_op == MEMOP_LH) || (slot_i.mem_op == MEMOP_LHU) ||
                   (slot_i.mem_op == MEMOP_LW);
  assign is_store = (slot_i.mem_op == MEMOP_SB) || (slot_i.mem_op == MEMOP_SH) ||
                    (slot_i.mem_op == MEMOP_SW);

  assign mem_req = slot_i.valid && (is_load || is_store);
  assign lane    = slot_i.alu_data[1:0];  // byte offset in the word

  // one bus cycle per slot, the slot is held by stall until ack
  always_comb begin
    state_d  = state_q;
    wb_cyc_o = 1'b0;
    case (state_q)
      IDLE: begin
        if (mem_req) begin
          wb_cyc_o = 1'b1;  // start right in the first slot cycle
          if (!wb_i.ack) begin
            state_d = BUS;
          end
        end
      end
      BUS: begin
        wb_cyc_o = 1'b1;
        if (wb_i.ack) begin
          state_d = IDLE;
        end
      end
      default: begin
        state_d = IDLE;
      end
    endcase
  end

  assign wb_stb_o = wb_cyc_o;
  assign bus_done = wb_cyc_o && wb_i.ack;
  assign stall_o  = wb_cyc_o && !wb_i.ack;  // next issue goes in on the ack edge

  // request is built from the held slot so it stays stable
  always_comb begin
    wb_req_o.adr = {slot_i.alu_data[`XLEN-1:2], 2'b00};
    wb_req_o.dat = slot_i.rs2_data << {lane, 3'b000};
    wb_req_o.we  = is_store;
    case (slot_i.mem_op)
      MEMOP_SB: begin
        wb_req_o.sel = wb_sel_t'(1) << lane;
      end
      MEMOP_SH: begin
        wb_req_o.sel = wb_sel_t'(3) << {lane[1], 1'b0};
      end
      default: begin
        wb_req_o.sel = '1;  // sw and every load
      end
    endcase
  end

  // read word moved down so the lane sits at bit 0
  assign lane_data = wb_i.dat >> {lane, 3'b000};

  always_comb begin
    case (slot_i.mem_op)
      MEMOP_LB: begin
        load_data = {{(`XLEN-8){lane_data[7]}}, lane_data[7:0]};
      end
      MEMOP_LBU: begin
        load_data = {{(`XLEN-8){1'b0}}, lane_data[7:0]};
      end
      MEMOP_LH: begin
        load_data = {{(`XLEN-16){lane_data[15]}}, lane_data[15:0]};
      end
      MEMOP_LHU: begin
        load_data = {{(`XLEN-16){1'b0}}, lane_data[15:0]};
      end
      default: begin
        load_data = wb_i.dat;  // lw
      end
    endcase
  end

  // x0 is never written and stores have no rd
  assign rd_write = slot_i.valid && slot_i.rd_wen && (slot_i.rd_idx != '0) && !is_store;

  always_ff @(posedge clk) begin
    if (rst_i) begin
      state_q        <= IDLE;
      retire_valid_o <= 1'b0;
    end else begin
      state_q        <= state_d;
      retire_valid_o <= rd_write && (!is_load || bus_done);  // loads wait for ack
    end
  end

  always_ff @(posedge clk) begin
    retire_o.rd_idx  <= slot_i.rd_idx;
    retire_o.rd_data <= is_load ? load_data : slot_i.alu_data;
  end

endmodule

// File: verilog/pipe_stage_pkg.sv
package pipe_stage_pkg;

  import rv_types_pkg::*;

  // decoded operation at the issue port
  typedef struct packed {
    alu_op_t  alu_op;
    mem_op_t  mem_op;
    reg_idx_t rd_idx;
    logic     rd_wen;
    logic     use_imm;   // operand b from imm_data
    xlen_t    rs1_data;
    xlen_t    rs2_data;
    xlen_t    imm_data;
  } issue_t;

  // contents of the ex_mem register
  typedef struct packed {
    logic     valid;
    mem_op_t  mem_op;
    reg_idx_t rd_idx;
    logic     rd_wen;
    xlen_t    alu_data;  // result or effective address
    xlen_t    rs2_data;  // store data
  } ex_mem_t;

  // register file write in program order
  typedef struct packed {
    reg_idx_t rd_idx;
    xlen_t    rd_data;
  } retire_t;

  // master side of the data bus
  typedef struct packed {
    xlen_t   adr;
    xlen_t   dat;
    wb_sel_t sel;
    logic    we;
  } wb_req_t;

  // slave side of the data bus
  typedef struct packed {
    xlen_t dat;
    logic  ack;
  } wb_rsp_t;

endpackage

// File: verilog/rv_types_pkg.sv
`include "core_settings.svh"

package rv_types_pkg;

  typedef logic [`XLEN-1:0]          xlen_t;
  typedef logic [`REG_ADDRWIDTH-1:0] reg_idx_t;
  typedef logic [3:0]                alu_op_t;
  typedef logic [3:0]                mem_op_t;
  typedef logic [`WB_SEL_LEN-1:0]    wb_sel_t;

  // integer alu operations
  localparam alu_op_t ALU_ADD   = 4'd0;
  localparam alu_op_t ALU_SUB   = 4'd1;
  localparam alu_op_t ALU_SLL   = 4'd2;
  localparam alu_op_t ALU_SLT   = 4'd3;
  localparam alu_op_t ALU_SLTU  = 4'd4;
  localparam alu_op_t ALU_XOR   = 4'd5;
  localparam alu_op_t ALU_SRL   = 4'd6;
  localparam alu_op_t ALU_SRA   = 4'd7;
  localparam alu_op_t ALU_OR    = 4'd8;
  localparam alu_op_t ALU_AND   = 4'd9;
  localparam alu_op_t ALU_PASSB = 4'd10;  // lui style immediate

  // memory access kinds
  localparam mem_op_t MEMOP_NONE = 4'd0;
  localparam mem_op_t MEMOP_LB   = 4'd1;
  localparam mem_op_t MEMOP_LBU  = 4'd2;
  localparam mem_op_t MEMOP_LH   = 4'd3;
  localparam mem_op_t MEMOP_LHU  = 4'd4;
  localparam mem_op_t MEMOP_LW   = 4'd5;
  localparam mem_op_t MEMOP_SB   = 4'd6;  // stores from here on
  localparam mem_op_t MEMOP_SH   = 4'd7;
  localparam mem_op_t MEMOP_SW   = 4'd8;

endpackage
